// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary -j 0 --timescale 1ns/10ps
TOP      = cpuTb
FILELIST = sources.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== rtl/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  cpuPkg::wordT  opA,
    input  cpuPkg::wordT  opB,
    input  cpuPkg::aluOpT aluOp,
    output cpuPkg::wordT  result,
    output logic          zero
);

    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd:   result = opA + opB;
            cpuPkg::aluSub:   result = opA - opB;
            cpuPkg::aluAnd:   result = opA & opB;
            cpuPkg::aluOr:    result = opA | opB;
            cpuPkg::aluPassB: result = opB;
            default:          result = '0;
        endcase
    end

    // Branches compare by subtraction
    assign zero = (result == '0);

endmodule

// ==== rtl/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit (
    input  cpuPkg::wordT  instrId,
    output logic          regWrite,
    output logic          memToReg,
    output logic          memRead,
    output logic          memWrite,
    output logic          aluSrc,
    output cpuPkg::aluOpT aluOp,
    output logic          regDst,
    output logic          isBranch,
    output logic          branchOnEqual,
    output logic          isJump,
    output logic          isOutput,
    output logic          isHalt,
    output logic          useRs,
    output logic          useRt
);

    cpuPkg::opcodeT opcode;
    cpuPkg::funcT   func;

    assign opcode = instrId[15:12];
    assign func   = instrId[5:0];

    always_comb begin
        regWrite      = 1'b0;
        memToReg      = 1'b0;
        memRead       = 1'b0;
        memWrite      = 1'b0;
        aluSrc        = 1'b0;
        aluOp         = cpuPkg::aluAdd;
        regDst        = 1'b0;
        isBranch      = 1'b0;
        branchOnEqual = 1'b0;
        isJump        = 1'b0;
        isOutput      = 1'b0;
        isHalt        = 1'b0;
        useRs         = 1'b0;
        useRt         = 1'b0;
        case (opcode)
            cpuPkg::opRtype: begin
                case (func)
                    cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd, cpuPkg::fnOrr: begin
                        regWrite = 1'b1;
                        regDst   = 1'b1;
                        useRs    = 1'b1;
                        useRt    = 1'b1;
                        case (func)
                            cpuPkg::fnSub: aluOp = cpuPkg::aluSub;
                            cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
                            cpuPkg::fnOrr: aluOp = cpuPkg::aluOr;
                            default:       aluOp = cpuPkg::aluAdd;
                        endcase
                    end
                    cpuPkg::fnWwd: begin
                        isOutput = 1'b1;
                        useRs    = 1'b1;
                    end
                    cpuPkg::fnHlt: isHalt = 1'b1;
                    default: ;
                endcase
            end
            cpuPkg::opAdi, cpuPkg::opOri: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                useRs    = 1'b1;
                aluOp    = (opcode == cpuPkg::opOri) ? cpuPkg::aluOr : cpuPkg::aluAdd;
            end
            // LHI only needs the shifted immediate
            cpuPkg::opLhi: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = cpuPkg::aluPassB;
            end
            cpuPkg::opLwd: begin
                regWrite = 1'b1;
                memToReg = 1'b1;
                memRead  = 1'b1;
                aluSrc   = 1'b1;
                useRs    = 1'b1;
            end
            cpuPkg::opSwd: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                useRs    = 1'b1;
                useRt    = 1'b1;
            end
            cpuPkg::opBne, cpuPkg::opBeq: begin
                isBranch      = 1'b1;
                branchOnEqual = (opcode == cpuPkg::opBeq);
                aluOp         = cpuPkg::aluSub;
                useRs         = 1'b1;
                useRt         = 1'b1;
            end
            cpuPkg::opJmp: isJump = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== rtl/cpuPkg.sv ====
package cpuPkg;

    typedef logic [15:0] wordT;
    typedef logic [1:0]  regIdxT;
    typedef logic [3:0]  opcodeT;
    typedef logic [5:0]  funcT;
    typedef logic [2:0]  aluOpT;

    // Instruction fields
    //   opcode [15:12], rs [11:10], rt [9:8], rd [7:6], func [5:0]
    //   immediate [7:0], sign-extended except ORI which zero-extends
    //   jump target [11:0], upper four bits taken from the PC

    localparam opcodeT opBne   = 4'd0;
    localparam opcodeT opBeq   = 4'd1;
    localparam opcodeT opAdi   = 4'd4;
    localparam opcodeT opOri   = 4'd5;
    localparam opcodeT opLhi   = 4'd6;
    localparam opcodeT opLwd   = 4'd7;
    localparam opcodeT opSwd   = 4'd8;
    localparam opcodeT opJmp   = 4'd9;
    localparam opcodeT opRtype = 4'd15;

    localparam funcT fnAdd = 6'd0;
    localparam funcT fnSub = 6'd1;
    localparam funcT fnAnd = 6'd2;
    localparam funcT fnOrr = 6'd3;
    localparam funcT fnWwd = 6'd28;
    localparam funcT fnHlt = 6'd29;

    localparam aluOpT aluAdd   = 3'd0;
    localparam aluOpT aluSub   = 3'd1;
    localparam aluOpT aluAnd   = 3'd2;
    localparam aluOpT aluOr    = 3'd3;
    localparam aluOpT aluPassB = 3'd4;

endpackage

// ==== rtl/cpuTop.sv ====
`timescale 1ns/10ps

module cpuTop #(
    parameter cpuPkg::wordT resetPc = '0
) (
    input  logic         Clk,
    input  logic         arstN,
    output cpuPkg::wordT imemAddr,
    input  cpuPkg::wordT imemData,
    output cpuPkg::wordT dmemAddr,
    output cpuPkg::wordT dmemWdata,
    input  cpuPkg::wordT dmemRdata,
    output logic         dmemRead,
    output logic         dmemWrite,
    output cpuPkg::wordT outputPort,
    output logic         outputValid,
    output cpuPkg::wordT numInst,
    output logic         halted
);

    cpuPkg::wordT  instrId;
    cpuPkg::aluOpT aluOp;
    logic regWrite, memToReg, memRead, memWrite, aluSrc, regDst;
    logic isBranch, branchOnEqual, isJump, isOutput, isHalt, useRs, useRt;

    controlUnit controlUnit_i (.*);

    datapath #(.resetPc(resetPc)) datapath_i (.*);

endmodule

// ==== rtl/datapath.sv ====
`timescale 1ns/10ps

module datapath #(
    parameter cpuPkg::wordT resetPc = '0
) (
    input  logic          Clk,
    input  logic          arstN,
    output cpuPkg::wordT  imemAddr,
    input  cpuPkg::wordT  imemData,
    output cpuPkg::wordT  dmemAddr,
    output cpuPkg::wordT  dmemWdata,
    input  cpuPkg::wordT  dmemRdata,
    output logic          dmemRead,
    output logic          dmemWrite,
    input  logic          regWrite,
    input  logic          memToReg,
    input  logic          memRead,
    input  logic          memWrite,
    input  logic          aluSrc,
    input  cpuPkg::aluOpT aluOp,
    input  logic          regDst,
    input  logic          isBranch,
    input  logic          branchOnEqual,
    input  logic          isJump,
    input  logic          isOutput,
    input  logic          isHalt,
    input  logic          useRs,
    input  logic          useRt,
    output cpuPkg::wordT  instrId,
    output cpuPkg::wordT  outputPort,
    output logic          outputValid,
    output cpuPkg::wordT  numInst,
    output logic          halted
);

    cpuPkg::wordT pc, pcPlus1, outputReg;
    logic         haltFetch;

    cpuPkg::wordT ifIdPcPlus1, ifIdInstr;
    logic         ifIdValid;

    logic           idExValid, idExRegWrite, idExMemToReg, idExMemRead, idExMemWrite;
    logic           idExAluSrc, idExIsBranch, idExBranchOnEqual, idExIsOutput, idExIsHalt;
    cpuPkg::aluOpT  idExAluOp;
    cpuPkg::regIdxT idExRs, idExRt, idExDst;
    cpuPkg::wordT   idExPcPlus1, idExReadA, idExReadB, idExImm;

    logic           exMemValid, exMemRegWrite, exMemMemToReg, exMemMemRead, exMemMemWrite;
    logic           exMemIsOutput, exMemIsHalt;
    cpuPkg::regIdxT exMemDst;
    cpuPkg::wordT   exMemResult, exMemStoreData;

    logic           memWbValid, memWbRegWrite, memWbMemToReg, memWbIsOutput, memWbIsHalt;
    cpuPkg::regIdxT memWbDst;
    cpuPkg::wordT   memWbResult, memWbLoadData, wbData;

    cpuPkg::opcodeT idOpcode;
    cpuPkg::regIdxT idRs, idRt, idRd;
    cpuPkg::wordT   idReadA, idReadB, idImm, jumpTarget;
    logic           stall, jumpId, hltId, stopFetch;

    logic [1:0]   forwardA, forwardB;
    cpuPkg::wordT fwdA, fwdB, aluB, aluResult, branchTarget;
    logic         aluZero, branchTaken;

    assign imemAddr = pc;
    assign pcPlus1  = pc + 16'd1;

    // ID stage
    assign instrId    = ifIdInstr;
    assign idOpcode   = ifIdInstr[15:12];
    assign idRs       = ifIdInstr[11:10];
    assign idRt       = ifIdInstr[9:8];
    assign idRd       = ifIdInstr[7:6];
    assign jumpTarget = {ifIdPcPlus1[15:12], ifIdInstr[11:0]};

    always_comb begin
        if (idOpcode == cpuPkg::opLhi) begin
            idImm = {ifIdInstr[7:0], 8'h00};
        end else if (idOpcode == cpuPkg::opOri) begin
            idImm = {8'h00, ifIdInstr[7:0]};
        end else begin
            idImm = {{8{ifIdInstr[7]}}, ifIdInstr[7:0]};
        end
    end

    regFile regFile_i (
        .Clk(Clk), .arstN(arstN),
        .readIdxA(idRs), .readIdxB(idRt),
        .readDataA(idReadA), .readDataB(idReadB),
        .writeIdx(memWbDst), .writeData(wbData),
        .writeEnable(memWbValid && memWbRegWrite)
    );

    hazardUnit hazardUnit_i (
        .exRs(idExRs), .exRt(idExRt),
        .memRd(exMemDst), .memRegWrite(exMemValid && exMemRegWrite),
        .wbRd(memWbDst), .wbRegWrite(memWbValid && memWbRegWrite),
        .idRs(idRs), .idRt(idRt),
        .idUseRs(ifIdValid && useRs), .idUseRt(ifIdValid && useRt),
        .exMemRead(idExValid && idExMemRead), .exRd(idExDst),
        .forwardA(forwardA), .forwardB(forwardB), .stall(stall)
    );

    // EX stage
    assign fwdA = (forwardA == 2'b01) ? exMemResult :
                  (forwardA == 2'b10) ? wbData : idExReadA;
    assign fwdB = (forwardB == 2'b01) ? exMemResult :
                  (forwardB == 2'b10) ? wbData : idExReadB;
    assign aluB = idExAluSrc ? idExImm : fwdB;

    alu alu_i (.opA(fwdA), .opB(aluB), .aluOp(idExAluOp), .result(aluResult), .zero(aluZero));

    assign branchTarget = idExPcPlus1 + idExImm;
    assign branchTaken  = idExValid && idExIsBranch && (idExBranchOnEqual == aluZero);

    // A taken branch in EX squashes whatever sits in ID
    assign jumpId    = ifIdValid && isJump && !branchTaken;
    assign hltId     = ifIdValid && isHalt && !branchTaken;
    assign stopFetch = haltFetch || hltId;

    // MEM and WB
    assign dmemAddr    = exMemResult;
    assign dmemWdata   = exMemStoreData;
    assign dmemRead    = exMemValid && exMemMemRead;
    assign dmemWrite   = exMemValid && exMemMemWrite;
    assign wbData      = memWbMemToReg ? memWbLoadData : memWbResult;
    assign outputValid = memWbValid && memWbIsOutput;
    assign outputPort  = outputValid ? memWbResult : outputReg;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc         <= resetPc;
            haltFetch  <= 1'b0;
            ifIdValid  <= 1'b0;
            idExValid  <= 1'b0;
            exMemValid <= 1'b0;
            memWbValid <= 1'b0;
            halted     <= 1'b0;
            numInst    <= '0;
            outputReg  <= '0;
        end else begin
            if (branchTaken) begin
                pc <= branchTarget;
            end else if (jumpId) begin
                pc <= jumpTarget;
            end else if (!stall && !stopFetch) begin
                pc <= pcPlus1;
            end
            haltFetch <= stopFetch;
            if (branchTaken || jumpId || stopFetch) begin
                ifIdValid <= 1'b0;
            end else if (!stall) begin
                ifIdValid <= 1'b1;
            end
            idExValid  <= ifIdValid && !stall && !branchTaken;
            exMemValid <= idExValid;
            memWbValid <= exMemValid;
            // HLT reaches WB only after everything older has retired
            if (exMemValid && exMemIsHalt) begin
                halted <= 1'b1;
            end
            if (memWbValid && !memWbIsHalt) begin
                numInst <= numInst + 16'd1;
            end
            if (outputValid) begin
                outputReg <= memWbResult;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin
            ifIdInstr   <= imemData;
            ifIdPcPlus1 <= pcPlus1;
        end
        idExPcPlus1       <= ifIdPcPlus1;
        idExRs            <= idRs;
        idExRt            <= idRt;
        idExDst           <= regDst ? idRd : idRt;
        idExReadA         <= idReadA;
        idExReadB         <= idReadB;
        idExImm           <= idImm;
        idExRegWrite      <= regWrite;
        idExMemToReg      <= memToReg;
        idExMemRead       <= memRead;
        idExMemWrite      <= memWrite;
        idExAluSrc        <= aluSrc;
        idExAluOp         <= aluOp;
        idExIsBranch      <= isBranch;
        idExBranchOnEqual <= branchOnEqual;
        idExIsOutput      <= isOutput;
        idExIsHalt        <= isHalt;
        // WWD carries rs down the pipe as its result
        exMemResult       <= idExIsOutput ? fwdA : aluResult;
        exMemStoreData    <= fwdB;
        exMemDst          <= idExDst;
        exMemRegWrite     <= idExRegWrite;
        exMemMemToReg     <= idExMemToReg;
        exMemMemRead      <= idExMemRead;
        exMemMemWrite     <= idExMemWrite;
        exMemIsOutput     <= idExIsOutput;
        exMemIsHalt       <= idExIsHalt;
        memWbResult       <= exMemResult;
        memWbLoadData     <= dmemRdata;
        memWbDst          <= exMemDst;
        memWbRegWrite     <= exMemRegWrite;
        memWbMemToReg     <= exMemMemToReg;
        memWbIsOutput     <= exMemIsOutput;
        memWbIsHalt       <= exMemIsHalt;
    end

endmodule

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit (
    input  cpuPkg::regIdxT exRs,
    input  cpuPkg::regIdxT exRt,
    input  cpuPkg::regIdxT memRd,
    input  logic           memRegWrite,
    input  cpuPkg::regIdxT wbRd,
    input  logic           wbRegWrite,
    input  cpuPkg::regIdxT idRs,
    input  cpuPkg::regIdxT idRt,
    input  logic           idUseRs,
    input  logic           idUseRt,
    input  logic           exMemRead,
    input  cpuPkg::regIdxT exRd,
    output logic [1:0]     forwardA,
    output logic [1:0]     forwardB,
    output logic           stall
);

    // 01 takes the MEM result, 10 the WB result; MEM is younger and wins
    assign forwardA = (memRegWrite && memRd == exRs) ? 2'b01 :
                      (wbRegWrite && wbRd == exRs)   ? 2'b10 : 2'b00;
    assign forwardB = (memRegWrite && memRd == exRt) ? 2'b01 :
                      (wbRegWrite && wbRd == exRt)   ? 2'b10 : 2'b00;

    // Load result is not ready until WB
    assign stall = exMemRead &&
                   ((idUseRs && idRs == exRd) || (idUseRt && idRt == exRd));

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic           Clk,
    input  logic           arstN,
    input  cpuPkg::regIdxT readIdxA,
    input  cpuPkg::regIdxT readIdxB,
    output cpuPkg::wordT   readDataA,
    output cpuPkg::wordT   readDataB,
    input  cpuPkg::regIdxT writeIdx,
    input  cpuPkg::wordT   writeData,
    input  logic           writeEnable
);

    cpuPkg::wordT regs [4];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeIdx] <= writeData;
        end
    end

    // Same-cycle write is visible to the reader in ID
    assign readDataA = (writeEnable && writeIdx == readIdxA) ? writeData : regs[readIdxA];
    assign readDataB = (writeEnable && writeIdx == readIdxB) ? writeData : regs[readIdxB];

endmodule

// ==== sources.f ====
rtl/cpuPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/controlUnit.sv
rtl/datapath.sv
rtl/cpuTop.sv
tests/cpuTb.sv

// ==== tests/cpuTb.sv ====
`timescale 1ns/10ps

module cpuTb;

    localparam cpuPkg::wordT resetPc = 16'h0020;
    localparam int numPrograms = 20;
    localparam int progLen = 48;
    localparam int clkPeriod = 4;
    localparam int watchdogCycles = numPrograms * (progLen * 4 + 30);
    localparam cpuPkg::wordT hltWord = {cpuPkg::opRtype, 6'd0, cpuPkg::fnHlt};

    logic         Clk;
    logic         arstN;
    cpuPkg::wordT imemAddr, imemData, dmemAddr, dmemWdata, dmemRdata;
    cpuPkg::wordT outputPort, numInst;
    logic         dmemRead, dmemWrite, outputValid, halted;

    cpuPkg::wordT imem [256];
    cpuPkg::wordT dmem [256];
    cpuPkg::wordT modelMem [256];
    cpuPkg::wordT wwdQ [$];
    cpuPkg::wordT storeAddrQ [$];
    cpuPkg::wordT storeDataQ [$];
    int           modelRetired;
    int           progIdx;
    logic         loadPattern;
    logic [15:0]  lfsr;

    cpuTop #(.resetPc(resetPc)) dut_i (
        .Clk(Clk), .arstN(arstN),
        .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemRdata(dmemRdata),
        .dmemRead(dmemRead), .dmemWrite(dmemWrite),
        .outputPort(outputPort), .outputValid(outputValid),
        .numInst(numInst), .halted(halted)
    );

    // Both memories answer in the same cycle
    assign imemData  = imem[imemAddr[7:0]];
    assign dmemRdata = dmemRead ? dmem[dmemAddr[7:0]] : '0;

    always @(posedge Clk) begin
        if (loadPattern) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= memPattern(progIdx, i);
            end
        end else if (dmemWrite) begin
            dmem[dmemAddr[7:0]] <= dmemWdata;
        end
    end

    initial begin
        Clk = 1'b0;
        forever begin
            #(clkPeriod / 2) Clk = ~Clk;
        end
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout: the core never halted within %0d cycles", watchdogCycles);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    // Odd multiplier keeps every address distinct
    function automatic cpuPkg::wordT memPattern(int prog, int addr);
        return cpuPkg::wordT'(addr * 40503 + prog * 977 + 4660);
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsrStep();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] randBits(int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsrStep()};
        end
        return v;
    endfunction

    task automatic checkEq(input cpuPkg::wordT actual, input cpuPkg::wordT expected,
                           input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s, got %h expected %h",
                     $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic genProgram();
        cpuPkg::wordT   instr, target, addr;
        cpuPkg::regIdxT rs, rt, rd;
        logic [7:0]     imm;
        int             kind, off;
        for (int k = 0; k < progLen; k++) begin
            kind = int'(randBits(4)) % 13;
            rs = cpuPkg::regIdxT'(randBits(2));
            rt = cpuPkg::regIdxT'(randBits(2));
            rd = cpuPkg::regIdxT'(randBits(2));
            imm = 8'(randBits(8));
            // Forward only, at the latest onto the closing HLT
            off = int'(randBits(6)) % (progLen - k);
            target = resetPc + cpuPkg::wordT'(k + 1 + off);
            case (kind)
                0: instr = {cpuPkg::opRtype, rs, rt, rd, cpuPkg::fnAdd};
                1: instr = {cpuPkg::opRtype, rs, rt, rd, cpuPkg::fnSub};
                2: instr = {cpuPkg::opRtype, rs, rt, rd, cpuPkg::fnAnd};
                3: instr = {cpuPkg::opRtype, rs, rt, rd, cpuPkg::fnOrr};
                4: instr = {cpuPkg::opRtype, rs, rt, rd, cpuPkg::fnWwd};
                5: instr = {cpuPkg::opAdi, rs, rt, imm};
                6: instr = {cpuPkg::opOri, rs, rt, imm};
                7: instr = {cpuPkg::opLhi, rs, rt, imm};
                // Small offsets so loads often hit earlier stores
                8: instr = {cpuPkg::opLwd, rs, rt, 4'h0, imm[3:0]};
                9: instr = {cpuPkg::opSwd, rs, rt, 4'h0, imm[3:0]};
                10: instr = {cpuPkg::opBne, rs, rt, 8'(off)};
                11: instr = {cpuPkg::opBeq, rs, rt, 8'(off)};
                default: instr = {cpuPkg::opJmp, target[11:0]};
            endcase
            addr = resetPc + cpuPkg::wordT'(k);
            imem[addr[7:0]] = instr;
        end
        addr = resetPc + cpuPkg::wordT'(progLen);
        imem[addr[7:0]] = hltWord;
    endtask

    // Sequential ISA reference that runs one instruction per step
    task automatic runModel();
        cpuPkg::wordT   regs [4];
        cpuPkg::wordT   pc, nextPc, instr, a, b, simm, addr;
        cpuPkg::regIdxT rs, rt, rd;
        logic           done;
        int             steps;
        for (int i = 0; i < 4; i++) begin
            regs[i] = '0;
        end
        wwdQ.delete();
        storeAddrQ.delete();
        storeDataQ.delete();
        modelRetired = 0;
        pc = resetPc;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 4 * progLen) begin
            instr = imem[pc[7:0]];
            rs = instr[11:10];
            rt = instr[9:8];
            rd = instr[7:6];
            a = regs[rs];
            b = regs[rt];
            simm = {{8{instr[7]}}, instr[7:0]};
            nextPc = pc + 16'd1;
            steps++;
            case (instr[15:12])
                cpuPkg::opRtype: begin
                    case (instr[5:0])
                        cpuPkg::fnAdd: regs[rd] = a + b;
                        cpuPkg::fnSub: regs[rd] = a - b;
                        cpuPkg::fnAnd: regs[rd] = a & b;
                        cpuPkg::fnOrr: regs[rd] = a | b;
                        cpuPkg::fnWwd: wwdQ.push_back(a);
                        cpuPkg::fnHlt: done = 1'b1;
                        default: ;
                    endcase
                end
                cpuPkg::opAdi: regs[rt] = a + simm;
                cpuPkg::opOri: regs[rt] = a | {8'h00, instr[7:0]};
                cpuPkg::opLhi: regs[rt] = {instr[7:0], 8'h00};
                cpuPkg::opLwd: begin
                    addr = a + simm;
                    regs[rt] = modelMem[addr[7:0]];
                end
                cpuPkg::opSwd: begin
                    addr = a + simm;
                    modelMem[addr[7:0]] = b;
                    storeAddrQ.push_back(addr);
                    storeDataQ.push_back(b);
                end
                cpuPkg::opBne: if (a != b) nextPc = pc + 16'd1 + simm;
                cpuPkg::opBeq: if (a == b) nextPc = pc + 16'd1 + simm;
                cpuPkg::opJmp: nextPc = {nextPc[15:12], instr[11:0]};
                default: ;
            endcase
            if (!done) begin
                modelRetired++;
            end
            pc = nextPc;
        end
    endtask

    task automatic runProgram(int prog);
        int wwdIdx;
        int storeIdx;
        @(negedge Clk);
        arstN = 1'b0;
        progIdx = prog;
        loadPattern = 1'b1;
        genProgram();
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = memPattern(prog, i);
        end
        runModel();
        @(negedge Clk);
        loadPattern = 1'b0;
        repeat (2) @(negedge Clk);
        checkEq(cpuPkg::wordT'(halted), 16'd0, "halted in reset");
        checkEq(cpuPkg::wordT'(outputValid), 16'd0, "outputValid in reset");
        checkEq(cpuPkg::wordT'(dmemWrite), 16'd0, "dmemWrite in reset");
        checkEq(cpuPkg::wordT'(dmemRead), 16'd0, "dmemRead in reset");
        checkEq(numInst, 16'd0, "numInst in reset");
        checkEq(imemAddr, resetPc, "first fetch address");
        arstN = 1'b1;
        wwdIdx = 0;
        storeIdx = 0;
        while (!halted) begin
            @(negedge Clk);
            if (outputValid) begin
                checkEq(cpuPkg::wordT'(wwdIdx < wwdQ.size()), 16'd1, "extra WWD output");
                checkEq(outputPort, wwdQ[wwdIdx], $sformatf("WWD value %0d", wwdIdx));
                wwdIdx++;
            end else if (wwdIdx > 0) begin
                checkEq(outputPort, wwdQ[wwdIdx - 1], "outputPort hold");
            end
            if (dmemWrite) begin
                checkEq(cpuPkg::wordT'(storeIdx < storeAddrQ.size()), 16'd1, "extra store");
                checkEq(dmemAddr, storeAddrQ[storeIdx], $sformatf("store address %0d", storeIdx));
                checkEq(dmemWdata, storeDataQ[storeIdx], $sformatf("store data %0d", storeIdx));
                storeIdx++;
            end
        end
        checkEq(numInst, cpuPkg::wordT'(modelRetired), "retire count at halt");
        checkEq(cpuPkg::wordT'(wwdIdx), cpuPkg::wordT'(wwdQ.size()), "number of WWD outputs");
        checkEq(cpuPkg::wordT'(storeIdx), cpuPkg::wordT'(storeAddrQ.size()), "number of stores");
        repeat (10) begin
            @(negedge Clk);
            checkEq(cpuPkg::wordT'(outputValid), 16'd0, "WWD output after halt");
            checkEq(cpuPkg::wordT'(dmemWrite), 16'd0, "store after halt");
            checkEq(cpuPkg::wordT'(halted), 16'd1, "halted dropped");
            checkEq(numInst, cpuPkg::wordT'(modelRetired), "retire count after halt");
        end
        for (int i = 0; i < 256; i++) begin
            checkEq(dmem[i], modelMem[i], $sformatf("program %0d data word %0d", prog, i));
        end
    endtask

    initial begin
        lfsr = 16'd71;
        arstN = 1'b0;
        loadPattern = 1'b0;
        progIdx = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = hltWord;
        end
        for (int p = 0; p < numPrograms; p++) begin
            runProgram(p);
        end
        $display("Regression passed");
        $finish;
    end

endmodule
